// ==== verilog.f ====
common/rv_pkg.sv
core/alu.sv
core/reg_file.sv
core/core_ctrl.sv
source/word_ram.sv
source/apb_debug.sv
source/rv_top.sv
verif/rv_asserts.sv
verif/tb_rv_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_rv_top -f verilog.f -o sim \
  && ./obj_dir/sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "^ALL CHECKS PASSED$" sim.log \
  && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }

// ==== verif/tb_rv_top.sv ====
/*
  Directed testbench for the RV32I core with its APB debug port.
  Builds small programs with the assembler functions, loads them over
  APB, runs them until done_o and checks data memory against values
  worked out from the RV32I rules. Random operands come from an LFSR.
*/
`timescale 1ns/100ps

module tb_rv_top import rv_pkg::*; ();

  localparam int TIMEOUT = 200;

  localparam logic [2:0] OP_F3 [10] = '{F3_ADD, F3_ADD, F3_SLL, F3_SLT, F3_SLTU,
                                        F3_XOR, F3_SR, F3_SR, F3_OR, F3_AND};
  localparam logic [2:0] BR_F3 [6]  = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

  logic        clk;
  logic        rst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        done;
  logic [31:0] lfsr;
  word_t       prog [$];

  rv_top rv_top_i (.clk, .rst_n, .apb_i(apb_req), .apb_o(apb_rsp), .done_o(done));

  always #4 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic rand_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[XLEN-2:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic word_t asm_r(input logic [6:0] f7, input reg_idx_t rs2,
                                 input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
    instr_u ins;
    ins.r_fmt = '{f7, rs2, rs1, f3, rd, OPC_OP};
    return ins;
  endfunction

  function automatic word_t asm_i(input logic [11:0] imm, input reg_idx_t rs1,
                                 input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
    instr_u ins;
    ins.i_fmt = '{imm, rs1, f3, rd, opc};
    return ins;
  endfunction

  function automatic word_t asm_addi(input reg_idx_t rd, input reg_idx_t rs1,
                                    input logic [11:0] imm);
    return asm_i(imm, rs1, F3_ADD, rd, OPC_OP_IMM);
  endfunction

  function automatic word_t asm_s(input logic [11:0] imm, input reg_idx_t rs2, input reg_idx_t rs1);
    instr_u ins;
    ins.s_fmt = '{imm[11:5], rs2, rs1, F3_W, imm[4:0], OPC_STORE};
    return ins;
  endfunction

  function automatic word_t asm_b(input logic [12:0] imm, input reg_idx_t rs2,
                                 input reg_idx_t rs1, input logic [2:0] f3);
    instr_u ins;
    ins.b_fmt = '{imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    return ins;
  endfunction

  function automatic word_t asm_u(input logic [19:0] imm, input reg_idx_t rd,
                                 input logic [6:0] opc);
    instr_u ins;
    ins.u_fmt = '{imm, rd, opc};
    return ins;
  endfunction

  function automatic word_t asm_j(input logic [20:0] imm, input reg_idx_t rd);
    instr_u ins;
    ins.j_fmt = '{imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    return ins;
  endfunction

  function automatic void emit(input word_t w);
    prog.push_back(w);
  endfunction

  // LUI plus ADDI, upper part rounded for the sign of the low half
  function automatic void emit_li(input reg_idx_t rd, input word_t v);
    word_t hi;
    hi = v + 32'h800;
    emit(asm_u(hi[31:12], rd, OPC_LUI));
    emit(asm_addi(rd, rd, v[11:0]));
  endfunction

  function automatic void emit_sw(input reg_idx_t rs2, input int word_idx);
    emit(asm_s(12'(4 * word_idx), rs2, 5'd0));
  endfunction

  function automatic void begin_prog();
    prog.delete();
    emit(asm_addi(5'd10, 5'd0, 12'd0));
  endfunction

  // Raise a0 and spin in place
  function automatic void end_prog();
    emit(asm_addi(5'd10, 5'd0, 12'd1));
    emit(asm_j(21'd0, 5'd0));
  endfunction

  function automatic logic signed_less(input word_t a, input word_t b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  // Result of RV32I operation k, in OP_F3 order with SUB and SRA at 1 and 7
  function automatic word_t model_alu(input int k, input word_t a, input word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (k)
      0:       return a + b;
      1:       return a + ~b + 32'd1;
      2:       return a << sh;
      3:       return {31'b0, signed_less(a, b)};
      4:       return {31'b0, a < b};
      5:       return a ^ b;
      6:       return a >> sh;
      7:       return a[31] ? ~(~a >> sh) : (a >> sh);
      8:       return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic model_taken(input int k, input word_t a, input word_t b);
    case (k)
      0:       return a == b;
      1:       return a != b;
      2:       return signed_less(a, b);
      3:       return !signed_less(a, b);
      4:       return a < b;
      default: return !(a < b);
    endcase
  endfunction

  function automatic logic [6:0] alt_f7(input int k);
    return (k == 1 || k == 7) ? 7'h20 : 7'h00;
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    rst_n   <= 1'b0;
    apb_req <= '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
  endtask

  // One APB transfer, setup then access until pready
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input word_t wdata,
                          output word_t rdata, output logic err);
    int cnt;
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    cnt = 0;
    @(negedge clk);
    while (apb_rsp.pready !== 1'b1) begin
      if (cnt == 8) begin
        stop_run($sformatf("APB transfer to %h never saw pready", addr));
      end
      cnt++;
      @(negedge clk);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input word_t data, output logic err);
    word_t ignored;
    apb_xfer(1'b1, addr, data, ignored, err);
  endtask

  task automatic apb_read(input logic [11:0] addr, output word_t data, output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  task automatic write_word(input string name, input logic [11:0] addr, input word_t data);
    logic err;
    apb_write(addr, data, err);
    check_bit({name, " write error"}, 1'b0, err);
  endtask

  task automatic check_dmem(input string name, input int idx, input word_t exp);
    word_t rd;
    logic  err;
    apb_read(12'(APB_DMEM_BASE + 4 * idx), rd, err);
    check_bit({name, " read error"}, 1'b0, err);
    check_word(name, exp, rd);
  endtask

  task automatic wait_done(input string name);
    int cnt;
    cnt = 0;
    @(negedge clk);
    // Previous program may still hold a0 high until the clear retires
    while (done !== 1'b0) begin
      if (cnt == TIMEOUT) begin
        stop_run($sformatf("Timeout in %s, done_o did not clear after start", name));
      end
      cnt++;
      @(negedge clk);
    end
    cnt = 0;
    while (done !== 1'b1) begin
      if (cnt == TIMEOUT) begin
        stop_run($sformatf("Timeout in %s, done_o never rose", name));
      end
      cnt++;
      @(negedge clk);
    end
  endtask

  task automatic run_program(input string name);
    if (prog.size() > 32) begin
      stop_run($sformatf("Program %s does not fit in instruction memory", name));
    end
    for (int i = 0; i < prog.size(); i++) begin
      write_word({name, " imem load"}, 12'(APB_IMEM_BASE + 4 * i), prog[i]);
    end
    write_word({name, " start"}, APB_CTRL_ADDR, 32'd1);
    wait_done(name);
    write_word({name, " stop"}, APB_CTRL_ADDR, 32'd0);
  endtask

  task automatic apb_test();
    word_t iw [32];
    word_t dw [16];
    word_t rd;
    logic  err;
    for (int i = 0; i < 32; i++) begin
      iw[i] = rand_bits(32);
      write_word("apb imem", 12'(APB_IMEM_BASE + 4 * i), iw[i]);
    end
    for (int i = 0; i < 16; i++) begin
      dw[i] = rand_bits(32);
      write_word("apb dmem", 12'(APB_DMEM_BASE + 4 * i), dw[i]);
    end
    for (int i = 0; i < 32; i++) begin
      apb_read(12'(APB_IMEM_BASE + 4 * i), rd, err);
      check_bit("apb imem read error", 1'b0, err);
      check_word($sformatf("apb imem word %0d", i), iw[i], rd);
    end
    for (int i = 0; i < 16; i++) begin
      check_dmem($sformatf("apb dmem word %0d", i), i, dw[i]);
    end
    apb_read(12'h300, rd, err);
    check_bit("apb unmapped read", 1'b1, err);
    apb_write(12'h208, 32'd1, err);
    check_bit("apb unmapped write", 1'b1, err);
    apb_write(APB_STAT_ADDR, 32'h3, err);
    check_bit("apb status write", 1'b1, err);
    apb_read(APB_CTRL_ADDR, rd, err);
    check_word("apb control after refused writes", 32'd0, rd);
    // Park the core on a self loop
    iw[0] = asm_j(21'd0, 5'd0);
    write_word("apb park", APB_IMEM_BASE, iw[0]);
    write_word("apb start", APB_CTRL_ADDR, 32'd1);
    apb_read(APB_STAT_ADDR, rd, err);
    check_word("apb status running", 32'h1, rd);
    apb_write(APB_DMEM_BASE, ~dw[0], err);
    check_bit("apb dmem write while running", 1'b1, err);
    apb_write(12'(APB_IMEM_BASE + 4), ~iw[1], err);
    check_bit("apb imem write while running", 1'b1, err);
    apb_read(12'(APB_DMEM_BASE + 4), rd, err);
    check_bit("apb dmem read while running", 1'b1, err);
    write_word("apb stop", APB_CTRL_ADDR, 32'd0);
    apb_read(APB_STAT_ADDR, rd, err);
    check_word("apb status stopped", 32'h0, rd);
    check_dmem("apb dmem kept", 0, dw[0]);
    apb_read(12'(APB_IMEM_BASE + 4), rd, err);
    check_word("apb imem kept", iw[1], rd);
  endtask

  task automatic op_test();
    word_t       a;
    word_t       b;
    word_t       tmp;
    logic [11:0] imms [10];
    repeat (2) begin
      a = rand_bits(32);
      b = rand_bits(32);
      begin_prog();
      emit_li(5'd1, a);
      emit_li(5'd2, b);
      for (int k = 0; k < 10; k++) begin
        emit(asm_r(alt_f7(k), 5'd2, 5'd1, OP_F3[k], 5'd3));
        emit_sw(5'd3, k);
      end
      end_prog();
      run_program("op_reg");
      for (int k = 0; k < 10; k++) begin
        check_dmem($sformatf("op_reg %0d", k), k, model_alu(k, a, b));
      end
      // Immediate forms, no SUBI in RV32I
      begin_prog();
      emit_li(5'd1, a);
      for (int k = 0; k < 10; k++) begin
        if (k != 1) begin
          if (k == 2 || k == 6 || k == 7) begin
            tmp     = rand_bits(5);
            imms[k] = {alt_f7(k), tmp[4:0]};
          end else begin
            tmp     = rand_bits(12);
            imms[k] = tmp[11:0];
          end
          emit(asm_i(imms[k], 5'd1, OP_F3[k], 5'd3, OPC_OP_IMM));
          emit_sw(5'd3, k);
        end
      end
      end_prog();
      run_program("op_imm");
      for (int k = 0; k < 10; k++) begin
        if (k != 1) begin
          check_dmem($sformatf("op_imm %0d", k), k,
                     model_alu(k, a, {{20{imms[k][11]}}, imms[k]}));
        end
      end
    end
  endtask

  task automatic branch_test();
    word_t a;
    word_t b;
    for (int c = 0; c < 3; c++) begin
      a = rand_bits(32);
      if (c == 1) begin
        b = a;
      end else begin
        b = rand_bits(32);
      end
      // Opposite signs split the signed and unsigned orders
      if (c == 2) begin
        b[31] = ~a[31];
      end
      begin_prog();
      emit_li(5'd1, a);
      emit_li(5'd2, b);
      emit(asm_addi(5'd5, 5'd0, 12'd1));
      for (int k = 0; k < 6; k++) begin
        emit(asm_b(13'd12, 5'd2, 5'd1, BR_F3[k]));
        emit_sw(5'd0, k);
        emit(asm_j(21'd8, 5'd0));
        emit_sw(5'd5, k);
      end
      end_prog();
      run_program($sformatf("branch set %0d", c));
      for (int k = 0; k < 6; k++) begin
        check_dmem($sformatf("branch set %0d kind %0d", c, k), k,
                   {31'b0, model_taken(k, a, b)});
      end
    end
  endtask

  task automatic jump_test();
    word_t u;
    u = rand_bits(20);
    write_word("jump preload", 12'(APB_DMEM_BASE + 12), 32'hFFFF_FFFF);
    write_word("jump preload", 12'(APB_DMEM_BASE + 16), 32'hFFFF_FFFF);
    begin_prog();
    emit(asm_addi(5'd7, 5'd0, 12'd0));
    // JAL at 8 skips to 16
    emit(asm_j(21'd8, 5'd1));
    emit(asm_addi(5'd7, 5'd0, 12'd1));
    emit_sw(5'd1, 0);
    // JALR at 24 to odd 37 lands on the AUIPC at 36
    emit(asm_addi(5'd2, 5'd0, 12'd37));
    emit(asm_i(12'd0, 5'd2, 3'b000, 5'd3, OPC_JALR));
    emit(asm_addi(5'd7, 5'd0, 12'd1));
    emit(asm_addi(5'd7, 5'd0, 12'd1));
    emit(asm_u(u[19:0], 5'd4, OPC_AUIPC));
    emit_sw(5'd3, 1);
    emit_sw(5'd4, 2);
    emit(asm_addi(5'd0, 5'd0, 12'd55));
    emit_sw(5'd0, 3);
    emit_sw(5'd7, 4);
    end_prog();
    run_program("jump");
    check_dmem("jump jal link", 0, 32'd12);
    check_dmem("jump jalr link", 1, 32'd28);
    check_dmem("jump auipc", 2, 32'd36 + {u[19:0], 12'b0});
    check_dmem("jump x0 store", 3, 32'd0);
    check_dmem("jump skipped code", 4, 32'd0);
  endtask

  task automatic load_store_test();
    word_t d [4];
    word_t rd;
    word_t exp;
    logic  err;
    apply_reset();
    @(negedge clk);
    check_bit("load done before start", 1'b0, done);
    for (int i = 0; i < 4; i++) begin
      d[i] = rand_bits(32);
      write_word("load preload", 12'(APB_DMEM_BASE + 4 * i), d[i]);
    end
    begin_prog();
    for (int i = 0; i < 4; i++) begin
      emit(asm_i(12'(4 * i), 5'd0, F3_W, 5'(i + 1), OPC_LOAD));
    end
    emit(asm_r(7'h00, 5'd2, 5'd1, F3_ADD, 5'd5));
    emit(asm_r(7'h00, 5'd3, 5'd5, F3_ADD, 5'd5));
    emit(asm_r(7'h00, 5'd4, 5'd5, F3_ADD, 5'd5));
    emit_sw(5'd5, 8);
    // Negative store offset from a base register
    emit(asm_addi(5'd6, 5'd0, 12'd40));
    emit(asm_s(12'hFFC, 5'd2, 5'd6));
    end_prog();
    run_program("load");
    apb_read(APB_STAT_ADDR, rd, err);
    check_word("load status done", 32'h2, rd);
    for (int i = 0; i < 16; i++) begin
      if (i < 4) begin
        exp = d[i];
      end else if (i == 8) begin
        exp = d[0] + d[1] + d[2] + d[3];
      end else if (i == 9) begin
        exp = d[1];
      end else begin
        exp = '0;
      end
      check_dmem($sformatf("load dmem word %0d", i), i, exp);
    end
  endtask

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    apb_req = '0;
    lfsr    = 32'h8706;
    apply_reset();
    apb_test();
    op_test();
    branch_test();
    jump_test();
    load_store_test();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== verif/rv_asserts.sv ====
/*
  Concurrent checks bound into the core top level.
  Watches the APB setup and access order, the data memory write
  source while halted and PC alignment while the core runs.
*/
`timescale 1ns/100ps

module rv_asserts import rv_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input apb_req_t apb_i,
  input apb_rsp_t apb_o,
  input logic     run,
  input mem_wr_t  dmem_wr,
  input word_t    pc
);

  // pready answers only an access cycle that follows a setup cycle
  a_pready_access: assert property (@(posedge clk) disable iff (!rst_n)
    apb_o.pready |-> (apb_i.psel && apb_i.penable && $past(apb_i.psel && !apb_i.penable)))
    else $error("pready raised outside an APB access cycle");

  // Halted core leaves data memory to the debug port
  a_core_write_running: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_wr.we && !run) |-> (apb_i.psel && apb_i.penable && apb_i.pwrite))
    else $error("data memory written while halted without an APB write");

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    run |-> (pc[1:0] == 2'b00))
    else $error("PC not word aligned while running");

endmodule

bind rv_top rv_asserts u_asserts (
  .clk(clk),
  .rst_n(rst_n),
  .apb_i(apb_i),
  .apb_o(apb_o),
  .run(run),
  .dmem_wr(dmem_wr),
  .pc(pc)
);

// ==== source/rv_top.sv ====
/*
  Top level of the RV32I core with its debug port.
  Connects decode, ALU, register file, both RAMs and the APB slave.
  Data memory is written by the core while running and by the
  debug port while halted.
*/
`timescale 1ns/100ps

module rv_top import rv_pkg::*; #(
  parameter int IMEM_AW = 5,
  parameter int DMEM_AW = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  apb_req_t apb_i,
  output apb_rsp_t apb_o,
  output logic     done_o
);

  logic     run;
  logic     start;
  word_t    pc;
  word_t    instr;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    alu_a;
  word_t    alu_b;
  alu_op_e  alu_op;
  word_t    alu_res;
  logic     eq;
  logic     lt;
  logic     ltu;
  logic     rd_we;
  reg_idx_t rd;
  word_t    rd_data;
  word_t    core_daddr;
  word_t    core_drdata;
  mem_wr_t  core_dwr;
  word_t    dbg_iaddr;
  word_t    dbg_irdata;
  mem_wr_t  dbg_iwr;
  word_t    dbg_daddr;
  word_t    dbg_drdata;
  mem_wr_t  dbg_dwr;
  mem_wr_t  dmem_wr;

  // Debug access is refused while running, so only one source is live
  assign dmem_wr = run ? core_dwr : dbg_dwr;

  core_ctrl u_ctrl (
    .clk, .rst_n, .run_i(run), .start_i(start), .instr_i(instr), .pc_o(pc),
    .rs1_o(rs1), .rs2_o(rs2), .rs1_val_i(rs1_val), .rs2_val_i(rs2_val),
    .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_op_o(alu_op), .alu_res_i(alu_res),
    .eq_i(eq), .lt_i(lt), .ltu_i(ltu), .rd_we_o(rd_we), .rd_o(rd), .rd_data_o(rd_data),
    .dmem_addr_o(core_daddr), .dmem_rdata_i(core_drdata), .dmem_wr_o(core_dwr)
  );

  alu u_alu (
    .a_i(alu_a), .b_i(alu_b), .op_i(alu_op), .res_o(alu_res),
    .eq_o(eq), .lt_o(lt), .ltu_o(ltu)
  );

  reg_file u_regs (
    .clk, .rst_n, .rs1_i(rs1), .rs2_i(rs2), .rs1_o(rs1_val), .rs2_o(rs2_val),
    .we_i(rd_we), .rd_i(rd), .wd_i(rd_data), .done_o
  );

  apb_debug u_dbg (
    .clk, .rst_n, .apb_i, .apb_o, .done_i(done_o), .run_o(run), .start_o(start),
    .imem_addr_o(dbg_iaddr), .imem_rdata_i(dbg_irdata), .imem_wr_o(dbg_iwr),
    .dmem_addr_o(dbg_daddr), .dmem_rdata_i(dbg_drdata), .dmem_wr_o(dbg_dwr)
  );

  word_ram #(.AW(IMEM_AW)) u_imem (
    .clk, .rst_n,
    .raddr_a_i(pc[IMEM_AW+1:2]), .raddr_b_i(dbg_iaddr[IMEM_AW+1:2]),
    .rdata_a_o(instr), .rdata_b_o(dbg_irdata), .wr_i(dbg_iwr)
  );

  word_ram #(.AW(DMEM_AW)) u_dmem (
    .clk, .rst_n,
    .raddr_a_i(core_daddr[DMEM_AW+1:2]), .raddr_b_i(dbg_daddr[DMEM_AW+1:2]),
    .rdata_a_o(core_drdata), .rdata_b_o(dbg_drdata), .wr_i(dmem_wr)
  );

endmodule

// ==== source/apb_debug.sv ====
/*
  APB debug slave for program load and run control.
  Maps the instruction and data memory windows, the control word
  (bit 0 run) and the read-only status word (running, done).
  Memory windows are refused while the core runs. No wait states.
*/
`timescale 1ns/100ps

module apb_debug import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  apb_req_t apb_i,
  output apb_rsp_t apb_o,
  input  logic     done_i,
  output logic     run_o,
  output logic     start_o,
  output word_t    imem_addr_o,
  input  word_t    imem_rdata_i,
  output mem_wr_t  imem_wr_o,
  output word_t    dmem_addr_o,
  input  word_t    dmem_rdata_i,
  output mem_wr_t  dmem_wr_o
);

  logic  access;
  logic  in_imem;
  logic  in_dmem;
  logic  is_ctrl;
  logic  is_stat;
  logic  err;
  logic  wr_ok;
  logic  run;
  word_t rdata;

  assign access  = apb_i.psel & apb_i.penable;
  assign in_imem = (apb_i.paddr & ~APB_WIN_MASK) == APB_IMEM_BASE;
  assign in_dmem = (apb_i.paddr & ~APB_WIN_MASK) == APB_DMEM_BASE;
  assign is_ctrl = apb_i.paddr == APB_CTRL_ADDR;
  assign is_stat = apb_i.paddr == APB_STAT_ADDR;

  // Unmapped, memory while running, or a write to status
  assign err = ~(in_imem | in_dmem | is_ctrl | is_stat)
             | ((in_imem | in_dmem) & run)
             | (is_stat & apb_i.pwrite);

  assign wr_ok = access & apb_i.pwrite & ~err;

  // Byte offset inside the window
  assign imem_addr_o = word_t'(apb_i.paddr & APB_WIN_MASK);
  assign dmem_addr_o = word_t'(apb_i.paddr & APB_WIN_MASK);

  assign imem_wr_o = '{we: wr_ok & in_imem, addr: apb_i.paddr[WADDR_W+1:2],
                       data: apb_i.pwdata};
  assign dmem_wr_o = '{we: wr_ok & in_dmem, addr: apb_i.paddr[WADDR_W+1:2],
                       data: apb_i.pwdata};

  always_comb begin
    if (err) begin
      rdata = '0;
    end else if (in_imem) begin
      rdata = imem_rdata_i;
    end else if (in_dmem) begin
      rdata = dmem_rdata_i;
    end else if (is_ctrl) begin
      rdata = word_t'(run);
    end else begin
      rdata = word_t'({done_i, run});
    end
  end

  assign apb_o = '{pready: access, pslverr: access & err, prdata: rdata};

  // Run flag, a 0 to 1 write also restarts the PC
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run <= 1'b0;
    end else if (wr_ok && is_ctrl) begin
      run <= apb_i.pwdata[0];
    end
  end

  assign start_o = wr_ok & is_ctrl & apb_i.pwdata[0] & ~run;
  assign run_o   = run;

endmodule

// ==== source/word_ram.sv ====
/*
  Word-addressed RAM of 2**AW words.
  Two combinational read ports, one for the core and one for the
  debug port, and a single full-word write port taken at the clock
  edge. Contents clear on reset. AW must not exceed WADDR_W.
*/
`timescale 1ns/100ps

module word_ram import rv_pkg::*; #(
  parameter int AW = 4
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic [AW-1:0] raddr_a_i,
  input  logic [AW-1:0] raddr_b_i,
  output word_t         rdata_a_o,
  output word_t         rdata_b_o,
  input  mem_wr_t       wr_i
);

  word_t mem [0:(1<<AW)-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < (1 << AW); i++) begin
        mem[i] <= '0;
      end
    end else if (wr_i.we) begin
      mem[wr_i.addr[AW-1:0]] <= wr_i.data;
    end
  end

  assign rdata_a_o = mem[raddr_a_i];
  assign rdata_b_o = mem[raddr_b_i];

endmodule

// ==== core/core_ctrl.sv ====
/*
  Decode and control for the single-cycle core.
  Views the fetched word through the format union, builds the
  immediates, steers the ALU, picks the next PC and the write-back
  value, and owns the PC. Every state update is gated by run_i.
*/
`timescale 1ns/100ps

module core_ctrl import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     run_i,
  input  logic     start_i,
  input  word_t    instr_i,
  output word_t    pc_o,
  output reg_idx_t rs1_o,
  output reg_idx_t rs2_o,
  input  word_t    rs1_val_i,
  input  word_t    rs2_val_i,
  output word_t    alu_a_o,
  output word_t    alu_b_o,
  output alu_op_e  alu_op_o,
  input  word_t    alu_res_i,
  input  logic     eq_i,
  input  logic     lt_i,
  input  logic     ltu_i,
  output logic     rd_we_o,
  output reg_idx_t rd_o,
  output word_t    rd_data_o,
  output word_t    dmem_addr_o,
  input  word_t    dmem_rdata_i,
  output mem_wr_t  dmem_wr_o
);

  instr_u  ins;
  word_t   pc;
  word_t   pc_plus4;
  word_t   pc_target;
  word_t   next_pc;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_u;
  word_t   imm_j;
  logic    is_ld_w;
  logic    is_st_w;
  logic    taken;
  logic    wb_en;
  alu_op_e arith_op;

  assign ins = instr_i;

  assign imm_i = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
  assign imm_s = {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
  assign imm_b = {{19{ins.b_fmt.imm12}}, ins.b_fmt.imm12, ins.b_fmt.imm11,
                  ins.b_fmt.imm10_5, ins.b_fmt.imm4_1, 1'b0};
  assign imm_u = {ins.u_fmt.imm, 12'b0};
  assign imm_j = {{11{ins.j_fmt.imm20}}, ins.j_fmt.imm20, ins.j_fmt.imm19_12,
                  ins.j_fmt.imm11, ins.j_fmt.imm10_1, 1'b0};

  // Only full-word memory accesses are decoded, others fall through as NOPs
  assign is_ld_w = (ins.i_fmt.opcode == OPC_LOAD) && (ins.i_fmt.funct3 == F3_W);
  assign is_st_w = (ins.s_fmt.opcode == OPC_STORE) && (ins.s_fmt.funct3 == F3_W);

  assign pc_plus4  = pc + 32'd4;
  // One adder for both PC-relative jump targets
  assign pc_target = pc + ((ins.j_fmt.opcode == OPC_JAL) ? imm_j : imm_b);

  // funct7 bit 5 selects SUB only for OP, SRA for both shift forms
  always_comb begin
    case (ins.r_fmt.funct3)
      F3_ADD:  arith_op = (ins.r_fmt.funct7[5] && ins.r_fmt.opcode == OPC_OP) ?
                          ALU_SUB : ALU_ADD;
      F3_SLL:  arith_op = ALU_SLL;
      F3_SLT:  arith_op = ALU_SLT;
      F3_SLTU: arith_op = ALU_SLTU;
      F3_XOR:  arith_op = ALU_XOR;
      F3_SR:   arith_op = ins.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL;
      F3_OR:   arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    case (ins.b_fmt.funct3)
      F3_BEQ:  taken = eq_i;
      F3_BNE:  taken = ~eq_i;
      F3_BLT:  taken = lt_i;
      F3_BGE:  taken = ~lt_i;
      F3_BLTU: taken = ltu_i;
      F3_BGEU: taken = ~ltu_i;
      default: taken = 1'b0;
    endcase
  end

  // ALU operands, addresses and JALR targets go through the adder too
  always_comb begin
    alu_a_o  = rs1_val_i;
    alu_b_o  = rs2_val_i;
    alu_op_o = ALU_ADD;
    case (ins.r_fmt.opcode)
      OPC_AUIPC: begin
        alu_a_o = pc;
        alu_b_o = imm_u;
      end
      OPC_JALR,
      OPC_LOAD:   alu_b_o = imm_i;
      OPC_STORE:  alu_b_o = imm_s;
      OPC_BRANCH: alu_op_o = ALU_SUB;
      OPC_OP_IMM: begin
        alu_b_o  = imm_i;
        alu_op_o = arith_op;
      end
      OPC_OP:     alu_op_o = arith_op;
      default:    alu_op_o = ALU_ADD;
    endcase
  end

  // Write-back value and next PC
  always_comb begin
    wb_en     = 1'b0;
    rd_data_o = alu_res_i;
    next_pc   = pc_plus4;
    case (ins.r_fmt.opcode)
      OPC_LUI: begin
        wb_en     = 1'b1;
        rd_data_o = imm_u;
      end
      OPC_AUIPC,
      OPC_OP_IMM,
      OPC_OP:  wb_en = 1'b1;
      OPC_JAL: begin
        wb_en     = 1'b1;
        rd_data_o = pc_plus4;
        next_pc   = pc_target;
      end
      OPC_JALR: begin
        wb_en     = 1'b1;
        rd_data_o = pc_plus4;
        next_pc   = {alu_res_i[XLEN-1:1], 1'b0};
      end
      OPC_BRANCH: begin
        if (taken) begin
          next_pc = pc_target;
        end
      end
      OPC_LOAD: begin
        wb_en     = is_ld_w;
        rd_data_o = dmem_rdata_i;
      end
      default: wb_en = 1'b0;
    endcase
  end

  assign rs1_o       = ins.r_fmt.rs1;
  assign rs2_o       = ins.r_fmt.rs2;
  assign rd_o        = ins.r_fmt.rd;
  assign rd_we_o     = run_i & wb_en;
  assign dmem_addr_o = alu_res_i;
  assign dmem_wr_o   = '{we: run_i & is_st_w, addr: alu_res_i[WADDR_W+1:2], data: rs2_val_i};
  assign pc_o        = pc;

  // Start restarts the program from address 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (start_i) begin
      pc <= '0;
    end else if (run_i) begin
      pc <= next_pc;
    end
  end

endmodule

// ==== core/reg_file.sv ====
/*
  Integer register file with x0 tied to zero.
  Two combinational read ports and one write port, written at the
  clock edge. Bit 0 of x10 drives the done flag.
*/
`timescale 1ns/100ps

module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  output word_t    rs1_o,
  output word_t    rs2_o,
  input  logic     we_i,
  input  reg_idx_t rd_i,
  input  word_t    wd_i,
  output logic     done_o
);

  // No storage behind x0
  word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs[rd_i] <= wd_i;
    end
  end

  assign rs1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  // a0 bit 0 signals program completion
  assign done_o = regs[10][0];

endmodule

// ==== core/alu.sv ====
/*
  Combinational ALU for the execute stage.
  Computes the ten RV32I register operations and the equal, signed
  less-than and unsigned less-than flags used by SLT and branches.
*/
`timescale 1ns/100ps

module alu import rv_pkg::*; (
  input  word_t   a_i,
  input  word_t   b_i,
  input  alu_op_e op_i,
  output word_t   res_o,
  output logic    eq_o,
  output logic    lt_o,
  output logic    ltu_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  // Compares shared by SLT, SLTU and the branch unit
  assign eq_o  = (a_i == b_i);
  assign lt_o  = ($signed(a_i) < $signed(b_i));
  assign ltu_o = (a_i < b_i);

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = a_i + b_i;
      ALU_SUB:  res_o = a_i - b_i;
      ALU_SLL:  res_o = a_i << shamt;
      ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_o};
      ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, ltu_o};
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_SRL:  res_o = a_i >> shamt;
      // Sign bit fills from the left
      ALU_SRA:  res_o = word_t'($signed(a_i) >>> shamt);
      ALU_OR:   res_o = a_i | b_i;
      ALU_AND:  res_o = a_i & b_i;
      default:  res_o = '0;
    endcase
  end

endmodule

// ==== common/rv_pkg.sv ====
/*
  Shared types and constants for the single-cycle RV32I core.
  Holds the word and register index types, the opcode and funct3
  encodings, the ALU operation enum, the instruction format union,
  the memory write port and the APB request and response structs.
  Modules pull it in with a wildcard import in their header.
*/
package rv_pkg;

  localparam int XLEN    = 32;
  localparam int REG_AW  = 5;
  // Word address width carried by a memory write port
  localparam int WADDR_W = 5;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

  // Major opcodes kept by this core
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // OP and OP-IMM operations, plus the word size for LW and SW
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_W    = 3'b010;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One instruction word, seen through each encoding format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  typedef struct packed {
    logic               we;
    logic [WADDR_W-1:0] addr;
    word_t              data;
  } mem_wr_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    word_t       pwdata;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    logic  pslverr;
    word_t prdata;
  } apb_rsp_t;

  // Debug address map, memory windows span 256 bytes each
  localparam logic [11:0] APB_IMEM_BASE = 12'h000;
  localparam logic [11:0] APB_DMEM_BASE = 12'h100;
  localparam logic [11:0] APB_WIN_MASK  = 12'h0FF;
  localparam logic [11:0] APB_CTRL_ADDR = 12'h200;
  localparam logic [11:0] APB_STAT_ADDR = 12'h204;

endpackage
